// ==== design/mips_pkg.sv ====
package mips_pkg;

  localparam int XLEN = 32;
  localparam int NREG = 32;
  localparam int RIDX = 5;

  localparam int IMEM_DEPTH = 64;
  localparam int DMEM_DEPTH = 64;
  localparam int MEM_AW     = 6;  // Word index from byte address bits 7:2

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_ADDIU = 6'h09,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } op_e;

  typedef enum logic [5:0] {
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_SLT  = 6'h2a
  } funct_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  typedef struct packed {
    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    is_branch;
    logic    is_jump;
  } ctrl_t;

endpackage

// ==== design/pipe_bus_if.sv ====
`timescale 1ns/1ps

interface dec_exe_if import mips_pkg::*; ();
  logic            valid;
  ctrl_t           ctrl;
  logic [XLEN-1:0] rs_val;
  logic [XLEN-1:0] rt_val;
  logic [XLEN-1:0] imm;
  logic [RIDX-1:0] rs;
  logic [RIDX-1:0] rt;
  logic [RIDX-1:0] dest;
  logic [XLEN-1:0] pc4;
  logic [XLEN-1:0] jump_target;

  modport dec (output valid, ctrl, rs_val, rt_val, imm, rs, rt, dest, pc4, jump_target);
  modport exe (input valid, ctrl, rs_val, rt_val, imm, rs, rt, dest, pc4, jump_target);
endinterface

interface exe_mem_if import mips_pkg::*; ();
  logic            valid;
  logic            reg_write;
  logic            mem_read;
  logic            mem_write;
  logic [RIDX-1:0] dest;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] store_data;  // Forwarded rt value

  modport exe (output valid, reg_write, mem_read, mem_write, dest, alu_result, store_data);
  modport mem (input valid, reg_write, mem_read, mem_write, dest, alu_result, store_data);
endinterface

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_step,
  input  logic            i_imem_we,
  input  logic [XLEN-1:0] i_imem_addr,
  input  logic [XLEN-1:0] i_imem_data,
  input  logic            i_redirect,
  input  logic [XLEN-1:0] i_redirect_pc,
  output logic [XLEN-1:0] o_pc,
  output logic [XLEN-1:0] o_instr,
  output logic [XLEN-1:0] o_pc4,
  output logic            o_valid
);

  logic [XLEN-1:0] imem [IMEM_DEPTH];
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;
  assign o_pc     = pc;

  // Load port, independent of step
  always_ff @(posedge i_clk) begin
    if (i_imem_we) begin
      imem[i_imem_addr[MEM_AW+1:2]] <= i_imem_data;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc      <= '0;
      o_valid <= 1'b0;
    end else if (i_step) begin
      pc      <= i_redirect ? i_redirect_pc : pc_plus4;
      o_valid <= ~i_redirect;  // Wrong-path fetch becomes a bubble
    end
  end

  // IF/ID payload
  always_ff @(posedge i_clk) begin
    if (i_step) begin
      o_instr <= imem[pc[MEM_AW+1:2]];
      o_pc4   <= pc_plus4;
    end
  end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_step,
  input  logic [XLEN-1:0] i_instr,
  input  logic [XLEN-1:0] i_pc4,
  input  logic            i_valid,
  input  logic            i_redirect,
  input  logic            i_wb_we,
  input  logic [RIDX-1:0] i_wb_dest,
  input  logic [XLEN-1:0] i_wb_data,
  input  logic [RIDX-1:0] i_dbg_reg,
  output logic [XLEN-1:0] o_dbg_reg_data,
  dec_exe_if.dec          bus
);

  logic [XLEN-1:0] regs [NREG];

  op_e             op;
  funct_e          funct;
  logic [RIDX-1:0] rs;
  logic [RIDX-1:0] rt;
  logic [RIDX-1:0] rd;
  ctrl_t           ctrl_d;
  logic [XLEN-1:0] imm_ext;
  logic [RIDX-1:0] dest_d;
  logic [XLEN-1:0] rs_rd;
  logic [XLEN-1:0] rt_rd;

  assign op    = op_e'(i_instr[31:26]);
  assign funct = funct_e'(i_instr[5:0]);
  assign rs    = i_instr[25:21];
  assign rt    = i_instr[20:16];
  assign rd    = i_instr[15:11];

  assign imm_ext = {{16{i_instr[15]}}, i_instr[15:0]};
  assign dest_d  = (op == OP_RTYPE) ? rd : rt;

  always_comb begin
    ctrl_d = '0;  // Unknown encodings decode as a nop
    case (op)
      OP_RTYPE: begin
        ctrl_d.reg_write = 1'b1;
        case (funct)
          FN_ADDU: ctrl_d.alu_op = ALU_ADD;
          FN_SUBU: ctrl_d.alu_op = ALU_SUB;
          FN_AND:  ctrl_d.alu_op = ALU_AND;
          FN_OR:   ctrl_d.alu_op = ALU_OR;
          FN_SLT:  ctrl_d.alu_op = ALU_SLT;
          default: ctrl_d.reg_write = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.reg_write   = 1'b1;
      end
      OP_LW: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.reg_write   = 1'b1;
        ctrl_d.mem_read    = 1'b1;
      end
      OP_SW: begin
        ctrl_d.alu_src_imm = 1'b1;
        ctrl_d.mem_write   = 1'b1;
      end
      OP_BEQ: begin
        ctrl_d.alu_op    = ALU_SUB;
        ctrl_d.is_branch = 1'b1;
      end
      OP_J:    ctrl_d.is_jump = 1'b1;
      default: ctrl_d = '0;
    endcase
  end

  // Write-first read, r0 hardwired to zero
  assign rs_rd = (rs == '0) ? '0 : (i_wb_we && i_wb_dest == rs) ? i_wb_data : regs[rs];
  assign rt_rd = (rt == '0) ? '0 : (i_wb_we && i_wb_dest == rt) ? i_wb_data : regs[rt];

  assign o_dbg_reg_data = regs[i_dbg_reg];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (i_step && i_wb_we && i_wb_dest != '0) begin
      regs[i_wb_dest] <= i_wb_data;
    end
  end

  // ID/EX control
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bus.valid <= 1'b0;
      bus.ctrl  <= '0;
    end else if (i_step) begin
      bus.valid <= i_valid & ~i_redirect;
      bus.ctrl  <= ctrl_d;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step) begin
      bus.rs_val      <= rs_rd;
      bus.rt_val      <= rt_rd;
      bus.imm         <= imm_ext;
      bus.rs          <= rs;
      bus.rt          <= rt;
      bus.dest        <= dest_d;
      bus.pc4         <= i_pc4;
      bus.jump_target <= {i_pc4[31:28], i_instr[25:0], 2'b00};
    end
  end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_step,
  dec_exe_if.exe          bus_in,
  input  logic            i_mem_fwd_we,
  input  logic [RIDX-1:0] i_mem_fwd_dest,
  input  logic [XLEN-1:0] i_mem_fwd_data,
  input  logic            i_wb_we,
  input  logic [RIDX-1:0] i_wb_dest,
  input  logic [XLEN-1:0] i_wb_data,
  output logic            o_redirect,
  output logic [XLEN-1:0] o_redirect_pc,
  output logic [XLEN-1:0] o_alu_result,
  exe_mem_if.exe          bus_out
);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b_reg;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_y;
  logic [XLEN-1:0] branch_target;
  logic            taken;

  // Newest producer wins
  function automatic logic [XLEN-1:0] fwd_sel(input logic [RIDX-1:0] idx,
                                              input logic [XLEN-1:0] reg_val);
    if (idx != '0 && i_mem_fwd_we && i_mem_fwd_dest == idx) begin
      return i_mem_fwd_data;
    end else if (idx != '0 && i_wb_we && i_wb_dest == idx) begin
      return i_wb_data;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a     = fwd_sel(bus_in.rs, bus_in.rs_val);
    op_b_reg = fwd_sel(bus_in.rt, bus_in.rt_val);
  end

  assign alu_b = bus_in.ctrl.alu_src_imm ? bus_in.imm : op_b_reg;

  always_comb begin
    case (bus_in.ctrl.alu_op)
      ALU_ADD: alu_y = op_a + alu_b;
      ALU_SUB: alu_y = op_a - alu_b;
      ALU_AND: alu_y = op_a & alu_b;
      ALU_OR:  alu_y = op_a | alu_b;
      ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      default: alu_y = '0;
    endcase
  end

  assign o_alu_result  = alu_y;
  assign branch_target = bus_in.pc4 + {bus_in.imm[XLEN-3:0], 2'b00};

  // BEQ subtracts, so equal operands give zero
  assign taken = (bus_in.ctrl.is_branch && alu_y == '0) || bus_in.ctrl.is_jump;

  assign o_redirect    = bus_in.valid & taken;
  assign o_redirect_pc = bus_in.ctrl.is_jump ? bus_in.jump_target : branch_target;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bus_out.valid     <= 1'b0;
      bus_out.reg_write <= 1'b0;
      bus_out.mem_read  <= 1'b0;
      bus_out.mem_write <= 1'b0;
    end else if (i_step) begin
      bus_out.valid     <= bus_in.valid;
      bus_out.reg_write <= bus_in.ctrl.reg_write;
      bus_out.mem_read  <= bus_in.ctrl.mem_read;
      bus_out.mem_write <= bus_in.ctrl.mem_write;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step) begin
      bus_out.dest       <= bus_in.dest;
      bus_out.alu_result <= alu_y;
      bus_out.store_data <= op_b_reg;
    end
  end

endmodule

// ==== design/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_step,
  exe_mem_if.mem          bus,
  input  logic [XLEN-1:0] i_dbg_addr,
  output logic [XLEN-1:0] o_dbg_mem_data,
  output logic            o_mem_fwd_we,
  output logic [RIDX-1:0] o_mem_fwd_dest,
  output logic [XLEN-1:0] o_mem_fwd_data,
  output logic            o_wb_we,
  output logic [RIDX-1:0] o_wb_dest,
  output logic [XLEN-1:0] o_wb_data
);

  logic [XLEN-1:0] dmem [DMEM_DEPTH];
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wb_load;
  logic [XLEN-1:0] wb_alu;
  logic            wb_sel_load;

  assign load_data      = dmem[bus.alu_result[MEM_AW+1:2]];
  assign o_dbg_mem_data = dmem[i_dbg_addr[MEM_AW+1:2]];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (i_step && bus.valid && bus.mem_write) begin
      dmem[bus.alu_result[MEM_AW+1:2]] <= bus.store_data;
    end
  end

  // Load data is not ready for EX, only ALU results forward from here
  assign o_mem_fwd_we   = bus.valid & bus.reg_write & ~bus.mem_read;
  assign o_mem_fwd_dest = bus.dest;
  assign o_mem_fwd_data = bus.alu_result;

  // MEM/WB
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_wb_we     <= 1'b0;
      wb_sel_load <= 1'b0;
    end else if (i_step) begin
      o_wb_we     <= bus.valid & bus.reg_write;
      wb_sel_load <= bus.mem_read;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_step) begin
      o_wb_dest <= bus.dest;
      wb_load   <= load_data;
      wb_alu    <= bus.alu_result;
    end
  end

  assign o_wb_data = wb_sel_load ? wb_load : wb_alu;

endmodule

// ==== design/mips_pipeline.sv ====
`timescale 1ns/1ps

module mips_pipeline import mips_pkg::*; (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_step,
  input  logic            i_imem_we,
  input  logic [XLEN-1:0] i_imem_addr,
  input  logic [XLEN-1:0] i_imem_data,
  input  logic [RIDX-1:0] i_dbg_reg,
  input  logic [XLEN-1:0] i_dbg_addr,
  output logic [XLEN-1:0] o_pc,
  output logic [XLEN-1:0] o_alu_result,
  output logic [XLEN-1:0] o_reg_data,
  output logic [XLEN-1:0] o_mem_data
);

  logic [XLEN-1:0] if_instr;
  logic [XLEN-1:0] if_pc4;
  logic            if_valid;
  logic            redirect;
  logic [XLEN-1:0] redirect_pc;
  logic            mem_fwd_we;
  logic [RIDX-1:0] mem_fwd_dest;
  logic [XLEN-1:0] mem_fwd_data;
  logic            wb_we;
  logic [RIDX-1:0] wb_dest;
  logic [XLEN-1:0] wb_data;

  dec_exe_if u_dec_exe ();
  exe_mem_if u_exe_mem ();

  fetch_stage u_fetch (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(i_step),
    .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr), .i_imem_data(i_imem_data),
    .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .o_pc(o_pc), .o_instr(if_instr), .o_pc4(if_pc4), .o_valid(if_valid)
  );

  decode_stage u_decode (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(i_step),
    .i_instr(if_instr), .i_pc4(if_pc4), .i_valid(if_valid), .i_redirect(redirect),
    .i_wb_we(wb_we), .i_wb_dest(wb_dest), .i_wb_data(wb_data),
    .i_dbg_reg(i_dbg_reg), .o_dbg_reg_data(o_reg_data), .bus(u_dec_exe.dec)
  );

  execute_stage u_execute (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(i_step), .bus_in(u_dec_exe.exe),
    .i_mem_fwd_we(mem_fwd_we), .i_mem_fwd_dest(mem_fwd_dest),
    .i_mem_fwd_data(mem_fwd_data),
    .i_wb_we(wb_we), .i_wb_dest(wb_dest), .i_wb_data(wb_data),
    .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_alu_result(o_alu_result), .bus_out(u_exe_mem.exe)
  );

  memory_stage u_memory (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_step(i_step), .bus(u_exe_mem.mem),
    .i_dbg_addr(i_dbg_addr), .o_dbg_mem_data(o_mem_data),
    .o_mem_fwd_we(mem_fwd_we), .o_mem_fwd_dest(mem_fwd_dest),
    .o_mem_fwd_data(mem_fwd_data),
    .o_wb_we(wb_we), .o_wb_dest(wb_dest), .o_wb_data(wb_data)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

// ==== testbench/tb_mips_pipeline.sv ====
`timescale 1ns/1ps

module tb_mips_pipeline import mips_pkg::*; ();

  localparam int HALT_IDX      = 23;
  localparam logic [XLEN-1:0] HALT_ADDR = HALT_IDX * 4;
  localparam int HALT_TIMEOUT  = 400;
  localparam int RESET_TIMEOUT = 20;
  localparam int NUM_SEL       = 13;
  localparam int ALU_CHECK_LAST = 13;  // Straight-line code ends before the BEQ at 14

  logic            clk;
  logic            rst_n;
  logic            step;
  logic            imem_we;
  logic [XLEN-1:0] imem_addr;
  logic [XLEN-1:0] imem_data;
  logic [RIDX-1:0] dbg_reg;
  logic [XLEN-1:0] dbg_addr;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] reg_data;
  logic [XLEN-1:0] mem_data;

  logic [XLEN-1:0] prog [IMEM_DEPTH];
  logic [XLEN-1:0] ref_regs [NREG];
  logic [XLEN-1:0] ref_mem [DMEM_DEPTH];
  logic [XLEN-1:0] ref_alu [IMEM_DEPTH];
  logic [RIDX-1:0] rsel [NUM_SEL];  // Distinct nonzero registers
  logic [XLEN-1:0] offs [3];
  int              errors;
  int              checks;

  tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(2)) u_clock_gen (
    .o_clk(clk), .o_rst_n(rst_n)
  );

  mips_pipeline DUT (
    .i_clk(clk), .i_rst_n(rst_n), .i_step(step),
    .i_imem_we(imem_we), .i_imem_addr(imem_addr), .i_imem_data(imem_data),
    .i_dbg_reg(dbg_reg), .i_dbg_addr(dbg_addr),
    .o_pc(pc), .o_alu_result(alu_result), .o_reg_data(reg_data), .o_mem_data(mem_data)
  );

  function automatic logic [XLEN-1:0] rtype_word(funct_e fn, logic [RIDX-1:0] rd,
                                                 logic [RIDX-1:0] rs, logic [RIDX-1:0] rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [XLEN-1:0] itype_word(op_e op, logic [RIDX-1:0] rt,
                                                 logic [RIDX-1:0] rs, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [XLEN-1:0] jtype_word(int idx);
    return {OP_J, 26'(idx)};
  endfunction

  function automatic void pick_registers();
    bit              used [NREG];
    logic [RIDX-1:0] r;
    foreach (used[i]) used[i] = 1'b0;
    used[0] = 1'b1;
    for (int n = 0; n < NUM_SEL; n++) begin
      r = RIDX'(1 + ($urandom % (NREG - 1)));
      while (used[r]) r = RIDX'((r % (NREG - 1)) + 1);  // Probe to the next free one
      used[r] = 1'b1;
      rsel[n] = r;
    end
  endfunction

  function automatic void build_program();
    logic [15:0] imm1;
    logic [15:0] imm2;
    logic [15:0] imm3;
    logic [15:0] imm4;
    imm1 = 16'($urandom) | 16'h0001;  // Odd so the second BEQ falls through
    imm2 = 16'($urandom);
    imm3 = 16'($urandom);
    imm4 = 16'($urandom);
    foreach (offs[i]) offs[i] = ($urandom % DMEM_DEPTH) * 4;
    // Unused words write r0 and are harmless if fetched
    for (int i = 0; i < IMEM_DEPTH; i++) prog[i] = rtype_word(FN_OR, 5'd0, i[5:1], i[4:0]);
    prog[0]  = itype_word(OP_ADDIU, rsel[0], 5'd0, imm1);
    prog[1]  = itype_word(OP_ADDIU, rsel[1], rsel[0], imm2);
    prog[2]  = rtype_word(FN_ADDU, rsel[2], rsel[0], rsel[1]);
    prog[3]  = rtype_word(FN_SUBU, rsel[3], rsel[2], rsel[0]);
    prog[4]  = rtype_word(FN_AND, rsel[4], rsel[3], rsel[2]);
    prog[5]  = rtype_word(FN_OR, rsel[5], rsel[4], rsel[1]);
    prog[6]  = rtype_word(FN_SLT, rsel[6], rsel[5], rsel[3]);
    prog[7]  = itype_word(OP_ADDIU, 5'd0, rsel[2], imm3);
    prog[8]  = rtype_word(FN_ADDU, rsel[7], 5'd0, rsel[6]);
    prog[9]  = itype_word(OP_SW, rsel[2], 5'd0, offs[0][15:0]);
    prog[10] = itype_word(OP_SW, rsel[5], 5'd0, offs[1][15:0]);
    prog[11] = itype_word(OP_LW, rsel[8], 5'd0, offs[0][15:0]);
    prog[12] = itype_word(OP_ADDIU, rsel[9], rsel[1], imm4);
    prog[13] = rtype_word(FN_ADDU, rsel[10], rsel[8], rsel[9]);
    prog[14] = itype_word(OP_BEQ, rsel[0], rsel[0], 16'd2);
    prog[15] = itype_word(OP_ADDIU, rsel[9], 5'd0, 16'd111);
    prog[16] = itype_word(OP_ADDIU, rsel[0], 5'd0, 16'd222);
    prog[17] = itype_word(OP_BEQ, rsel[2], rsel[1], 16'd1);
    prog[18] = itype_word(OP_ADDIU, rsel[11], rsel[10], imm2);
    prog[19] = jtype_word(21);
    prog[20] = itype_word(OP_ADDIU, rsel[1], 5'd0, 16'd333);
    prog[21] = itype_word(OP_SW, rsel[11], 5'd0, offs[2][15:0]);
    prog[22] = rtype_word(FN_SUBU, rsel[12], rsel[11], rsel[10]);
    prog[HALT_IDX] = jtype_word(HALT_IDX);
  endfunction

  // Interprets one instruction at a time
  function automatic void run_reference();
    logic [XLEN-1:0] rpc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] ins;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] simm;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] res;
    logic            wr;
    logic [RIDX-1:0] wdest;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    foreach (ref_mem[i]) ref_mem[i] = '0;
    rpc = '0;
    for (int n = 0; n < 1000 && rpc != HALT_ADDR; n++) begin
      ins     = prog[rpc[7:2]];
      a       = ref_regs[ins[25:21]];
      b       = ref_regs[ins[20:16]];
      simm    = {{16{ins[15]}}, ins[15:0]};
      addr    = a + simm;
      next_pc = rpc + 4;
      wr      = 1'b0;
      wdest   = ins[20:16];
      res     = '0;
      case (ins[31:26])
        6'h00: begin
          wr    = 1'b1;
          wdest = ins[15:11];
          case (ins[5:0])
            6'h21: res = a + b;
            6'h23: res = a - b;
            6'h24: res = a & b;
            6'h25: res = a | b;
            6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: wr = 1'b0;
          endcase
        end
        6'h09: begin
          wr  = 1'b1;
          res = a + simm;
        end
        6'h23: begin
          wr  = 1'b1;
          res = ref_mem[addr[7:2]];
        end
        6'h2b: ref_mem[addr[7:2]] = b;
        6'h04: if (a == b) next_pc = rpc + 4 + (simm << 2);
        6'h02: next_pc = {next_pc[31:28], ins[25:0], 2'b00};
        default: ;
      endcase
      // ALU output in EX is the address for loads and stores
      ref_alu[rpc[7:2]] = (ins[31:26] == 6'h00) ? res : addr;
      if (wr && wdest != '0) ref_regs[wdest] = res;
      rpc = next_pc;
    end
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic wait_for_reset(output logic done);
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    done = (rst_n === 1'b1);
    if (!done) begin
      errors++;
      $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
    end
  endtask

  task automatic check_reset_state();
    @(negedge clk);
    check_value("o_pc", pc, '0);
    for (int r = 0; r < NREG; r++) begin
      @(posedge clk);
      dbg_reg <= RIDX'(r);
      @(negedge clk);
      check_value($sformatf("o_reg_data[%0d]", r), reg_data, '0);
    end
  endtask

  task automatic load_imem();
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= i * 4;
      imem_data <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
  endtask

  task automatic run_to_halt(output logic done);
    int cycles;
    int hits;
    cycles = 0;
    hits   = 0;
    @(posedge clk);
    step <= 1'b1;
    // By the third arrival at the halt loop all older writes have retired
    while (hits < 3 && cycles < HALT_TIMEOUT) begin
      @(negedge clk);
      // Instruction i sits in EX after step edge i + 2
      if (cycles >= 2 && cycles - 2 <= ALU_CHECK_LAST) begin
        check_value($sformatf("o_alu_result[%0d]", cycles - 2), alu_result,
                    ref_alu[cycles - 2]);
      end
      if (pc == HALT_ADDR) hits++;
      cycles++;
    end
    @(posedge clk);
    step <= 1'b0;
    done = (hits == 3);
    if (!done) begin
      errors++;
      $display("Program did not reach halt address %h within %0d cycles", HALT_ADDR,
               HALT_TIMEOUT);
    end
  endtask

  task automatic check_stall_hold();
    int              hold;
    logic [XLEN-1:0] pc_snap;
    logic [XLEN-1:0] reg_snap;
    logic [XLEN-1:0] mem_snap;
    hold = 4 + ($urandom % 16);
    @(posedge clk);
    dbg_reg  <= rsel[2];
    dbg_addr <= offs[0];
    @(negedge clk);
    pc_snap  = pc;
    reg_snap = reg_data;
    mem_snap = mem_data;
    repeat (hold) begin
      @(negedge clk);
      check_value("o_pc (stalled)", pc, pc_snap);
      check_value("o_reg_data (stalled)", reg_data, reg_snap);
      check_value("o_mem_data (stalled)", mem_data, mem_snap);
    end
  endtask

  task automatic sweep_state();
    for (int r = 0; r < NREG; r++) begin
      @(posedge clk);
      dbg_reg <= RIDX'(r);
      @(negedge clk);
      check_value($sformatf("o_reg_data[%0d]", r), reg_data, ref_regs[r]);
    end
    for (int w = 0; w < DMEM_DEPTH; w++) begin
      @(posedge clk);
      dbg_addr <= w * 4;
      @(negedge clk);
      check_value($sformatf("o_mem_data[%0d]", w), mem_data, ref_mem[w]);
    end
  endtask

  task automatic report_results();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin : stimulus
    logic ok;
    void'($urandom(32'h8619));
    errors    = 0;
    checks    = 0;
    step      <= 1'b0;
    imem_we   <= 1'b0;
    imem_addr <= '0;
    imem_data <= '0;
    dbg_reg   <= '0;
    dbg_addr  <= '0;
    pick_registers();
    build_program();
    run_reference();
    wait_for_reset(ok);
    if (ok) begin
      check_reset_state();
      load_imem();
      run_to_halt(ok);
    end
    if (ok) begin
      check_stall_hold();
      sweep_state();
    end
    report_results();
  end

endmodule

// ==== files.f ====
design/mips_pkg.sv
design/pipe_bus_if.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_pipeline.sv
testbench/tb_clock_gen.sv
testbench/tb_mips_pipeline.sv

// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - files:
      - design/mips_pkg.sv
      - design/pipe_bus_if.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/execute_stage.sv
      - design/memory_stage.sv
      - design/mips_pipeline.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_mips_pipeline.sv
